//--- src/mshr_pkg.sv
`default_nettype none

package mshr_pkg;

  // hit_index is wide enough for queues of up to 16 entries
  localparam int INDEX_W = 4;

  typedef logic [31:0] line_addr_t;
  typedef logic [63:0] line_data_t;

  // zero means no transaction
  typedef logic [3:0] mem_tag_t;

  // credits handed back to the cache in one cycle
  typedef logic [1:0] credit_cnt_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_cmd_e;

  typedef enum logic [1:0] {
    WAITING     = 2'd0,
    IN_PROGRESS = 2'd1,
    DONE        = 2'd2
  } entry_state_e;

  typedef struct packed {
    logic         valid;
    line_addr_t   addr;
    line_data_t   data;
    bus_cmd_e     cmd;
    entry_state_e state;
    mem_tag_t     tag;
  } mshr_entry_t;

  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    line_data_t data;
  } miss_req_t;

  typedef struct packed {
    logic               alloc;
    logic               hit;
    logic [INDEX_W-1:0] hit_index;
  } filter_result_t;

endpackage

`default_nettype wire

//--- src/load_miss_filter.sv
`timescale 1ns/1ps
`default_nettype none

module load_miss_filter import mshr_pkg::*; #(
  parameter int MSHR_DEPTH = 8
) (
  input  logic                           clock,
  input  logic                           reset,
  input  miss_req_t                      req,
  input  mshr_entry_t [MSHR_DEPTH-1:0]   entries,
  output filter_result_t                 result,
  output logic                           fwd_valid,
  output line_data_t                     fwd_data
);

  localparam int PTR_W = $clog2(MSHR_DEPTH);
  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t free_idx;
  ptr_t st_idx;
  ptr_t ld_idx;
  logic st_hit;
  logic ld_hit;

  // valid entries form one circular run, so scanning from a free slot
  // visits them oldest first
  always_comb begin
    free_idx = '0;
    for (int i = MSHR_DEPTH - 1; i >= 0; i--) begin
      if (!entries[i].valid) begin
        free_idx = ptr_t'(i);
      end
    end
  end

  always_comb begin
    ptr_t idx;
    st_hit = 1'b0;
    st_idx = '0;
    ld_hit = 1'b0;
    ld_idx = '0;
    for (int k = 1; k <= MSHR_DEPTH; k++) begin
      idx = free_idx + ptr_t'(k);
      if (req.valid && entries[idx].valid && entries[idx].addr == req.addr) begin
        // newest writeback holds the latest data
        if (entries[idx].cmd == BUS_STORE) begin
          st_hit = 1'b1;
          st_idx = idx;
        end else if (!ld_hit) begin
          ld_hit = 1'b1;
          ld_idx = idx;
        end
      end
    end
  end

  // forwarding wins over merging
  assign result.alloc     = req.valid && !st_hit && !ld_hit;
  assign result.hit       = st_hit || ld_hit;
  assign result.hit_index = st_hit ? INDEX_W'(st_idx) : INDEX_W'(ld_idx);

  assign fwd_valid = st_hit;
  assign fwd_data  = entries[st_idx].data;

  // the oldest first scan needs a free slot whenever a request arrives
  assert property (@(posedge clock) disable iff (reset)
    req.valid |-> !entries[free_idx].valid);

endmodule

`default_nettype wire

//--- src/writeback_filter.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_filter import mshr_pkg::*; #(
  parameter int MSHR_DEPTH = 8
) (
  input  miss_req_t                      req,
  input  mshr_entry_t [MSHR_DEPTH-1:0]   entries,
  output filter_result_t                 result
);

  localparam int PTR_W = $clog2(MSHR_DEPTH);
  typedef logic [PTR_W-1:0] ptr_t;

  logic hit;
  ptr_t hit_idx;

  // at most one waiting store per address, so no ordering is needed
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (req.valid && entries[i].valid && entries[i].cmd == BUS_STORE &&
          entries[i].state == WAITING && entries[i].addr == req.addr) begin
        hit     = 1'b1;
        hit_idx = ptr_t'(i);
      end
    end
  end

  assign result.alloc     = req.valid && !hit;
  assign result.hit       = hit;
  assign result.hit_index = INDEX_W'(hit_idx);

endmodule

`default_nettype wire

//--- src/mshr_entry_table.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_table import mshr_pkg::*; #(
  parameter int MSHR_DEPTH = 8
) (
  input  logic                           clock,
  input  logic                           reset,
  input  miss_req_t                      load_req,
  input  miss_req_t                      wb_req,
  input  filter_result_t                 load_result,
  input  filter_result_t                 wb_result,
  input  logic                           accept,
  input  mem_tag_t                       accept_tag,
  input  mem_tag_t                       mem_tag,
  input  line_data_t                     mem_resp_data,
  output mshr_entry_t [MSHR_DEPTH-1:0]   entries,
  output mshr_entry_t                    head_entry,
  output logic                           fill_valid,
  output line_addr_t                     fill_addr,
  output line_data_t                     fill_data,
  output credit_cnt_t                    credit_return
);

  localparam int PTR_W = $clog2(MSHR_DEPTH);
  typedef logic [PTR_W-1:0] ptr_t;

  mshr_entry_t [MSHR_DEPTH-1:0] entries_q;
  mshr_entry_t [MSHR_DEPTH-1:0] entries_d;

  ptr_t tail_ptr;
  ptr_t head_ptr;
  ptr_t retire_ptr;
  ptr_t wb_slot;
  ptr_t wb_hit_idx;

  logic load_alloc;
  logic wb_alloc;
  logic wb_combine;
  logic wb_redirect;
  logic retire_fire;
  logic load_absorb;
  logic wb_absorb;
  logic [2:0] credit_sum;

  assign wb_hit_idx = ptr_t'(wb_result.hit_index);

  // waiting store taken by memory this very cycle, so the new data needs its own entry
  assign wb_redirect = wb_result.hit && accept && wb_hit_idx == head_ptr;
  assign wb_combine  = wb_req.valid && wb_result.hit && !wb_redirect;

  assign load_alloc = load_result.alloc;
  assign wb_alloc   = wb_result.alloc || (wb_req.valid && wb_redirect);
  assign wb_slot    = load_alloc ? tail_ptr + ptr_t'(1) : tail_ptr;

  assign load_absorb = load_req.valid && load_result.hit;
  assign wb_absorb   = wb_combine;

  assign retire_fire = entries_q[retire_ptr].valid && entries_q[retire_ptr].state == DONE;

  always_comb begin
    entries_d = entries_q;

    if (wb_combine) begin
      entries_d[wb_hit_idx].data = wb_req.data;
    end

    // a store is finished once memory takes it
    if (accept) begin
      entries_d[head_ptr].tag   = accept_tag;
      entries_d[head_ptr].state =
        (entries_q[head_ptr].cmd == BUS_STORE) ? DONE : IN_PROGRESS;
    end

    if (mem_tag != '0) begin
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        if (entries_q[i].valid && entries_q[i].cmd == BUS_LOAD &&
            entries_q[i].state == IN_PROGRESS && entries_q[i].tag == mem_tag) begin
          entries_d[i].state = DONE;
          entries_d[i].data  = mem_resp_data;
        end
      end
    end

    if (retire_fire) begin
      entries_d[retire_ptr].valid = 1'b0;
    end

    // load first, writeback behind it
    if (load_alloc) begin
      entries_d[tail_ptr].valid = 1'b1;
      entries_d[tail_ptr].addr  = load_req.addr;
      entries_d[tail_ptr].data  = load_req.data;
      entries_d[tail_ptr].cmd   = BUS_LOAD;
      entries_d[tail_ptr].state = WAITING;
      entries_d[tail_ptr].tag   = '0;
    end
    if (wb_alloc) begin
      entries_d[wb_slot].valid = 1'b1;
      entries_d[wb_slot].addr  = wb_req.addr;
      entries_d[wb_slot].data  = wb_req.data;
      entries_d[wb_slot].cmd   = BUS_STORE;
      entries_d[wb_slot].state = WAITING;
      entries_d[wb_slot].tag   = '0;
    end
  end

  assign credit_sum = 3'(load_absorb) + 3'(wb_absorb) + 3'(retire_fire);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        entries_q[i].valid <= 1'b0;
      end
      tail_ptr      <= '0;
      head_ptr      <= '0;
      retire_ptr    <= '0;
      credit_return <= '0;
    end else begin
      entries_q     <= entries_d;
      tail_ptr      <= tail_ptr + ptr_t'(load_alloc) + ptr_t'(wb_alloc);
      head_ptr      <= head_ptr + ptr_t'(accept);
      retire_ptr    <= retire_ptr + ptr_t'(retire_fire);
      credit_return <= credit_cnt_t'(credit_sum);
    end
  end

  assign entries    = entries_q;
  assign head_entry = entries_q[head_ptr];

  // fills only for loads while stores just free their slot
  assign fill_valid = retire_fire && entries_q[retire_ptr].cmd == BUS_LOAD;
  assign fill_addr  = entries_q[retire_ptr].addr;
  assign fill_data  = entries_q[retire_ptr].data;

  // relies on the cache spending its credits correctly
  assert property (@(posedge clock) disable iff (reset)
    load_alloc |-> !entries_q[tail_ptr].valid);

  assert property (@(posedge clock) disable iff (reset)
    wb_alloc |-> !entries_q[wb_slot].valid);

  // an empty retire slot means the whole queue is empty
  assert property (@(posedge clock) disable iff (reset)
    !entries_q[retire_ptr].valid |-> tail_ptr == retire_ptr);

endmodule

`default_nettype wire

//--- src/mem_request_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_request_ctrl import mshr_pkg::*; #(
  parameter int MSHR_DEPTH = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  mshr_entry_t head_entry,
  input  mem_tag_t    mem_response,
  output bus_cmd_e    mem_cmd,
  output line_addr_t  mem_addr,
  output line_data_t  mem_data,
  output logic        accept,
  output mem_tag_t    accept_tag
);

  localparam int PTR_W = $clog2(MSHR_DEPTH);
  typedef logic [PTR_W-1:0] ptr_t;

  // slot currently on the bus
  ptr_t head;
  logic issue;

  assign issue = head_entry.valid && head_entry.state == WAITING;

  assign mem_cmd  = issue ? head_entry.cmd : BUS_NONE;
  assign mem_addr = head_entry.addr;
  assign mem_data = head_entry.data;

  // nonzero response is both the acceptance and the tag
  assign accept     = issue && mem_response != '0;
  assign accept_tag = mem_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
    end else if (accept) begin
      head <= head + ptr_t'(1);
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    mem_response != '0 |-> mem_cmd != BUS_NONE)
    else $error("memory response with no command, head slot %0d", head);

endmodule

`default_nettype wire

//--- src/mshr_top.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_top import mshr_pkg::*; #(
  parameter int MSHR_DEPTH = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  miss_req_t   load_req,
  input  miss_req_t   wb_req,
  output logic        fwd_valid,
  output line_data_t  fwd_data,
  output logic        fill_valid,
  output line_addr_t  fill_addr,
  output line_data_t  fill_data,
  output credit_cnt_t credit_return,
  output bus_cmd_e    mem_cmd,
  output line_addr_t  mem_addr,
  output line_data_t  mem_data,
  input  mem_tag_t    mem_response,
  input  mem_tag_t    mem_tag,
  input  line_data_t  mem_resp_data
);

  mshr_entry_t [MSHR_DEPTH-1:0] entries;
  mshr_entry_t                  head_entry;
  filter_result_t               load_result;
  filter_result_t               wb_result;
  logic                         accept;
  mem_tag_t                     accept_tag;

  load_miss_filter #(.MSHR_DEPTH(MSHR_DEPTH)) i_load_filter (
    .clock     (clock),
    .reset     (reset),
    .req       (load_req),
    .entries   (entries),
    .result    (load_result),
    .fwd_valid (fwd_valid),
    .fwd_data  (fwd_data)
  );

  writeback_filter #(.MSHR_DEPTH(MSHR_DEPTH)) i_wb_filter (
    .req     (wb_req),
    .entries (entries),
    .result  (wb_result)
  );

  mshr_entry_table #(.MSHR_DEPTH(MSHR_DEPTH)) i_table (
    .clock         (clock),
    .reset         (reset),
    .load_req      (load_req),
    .wb_req        (wb_req),
    .load_result   (load_result),
    .wb_result     (wb_result),
    .accept        (accept),
    .accept_tag    (accept_tag),
    .mem_tag       (mem_tag),
    .mem_resp_data (mem_resp_data),
    .entries       (entries),
    .head_entry    (head_entry),
    .fill_valid    (fill_valid),
    .fill_addr     (fill_addr),
    .fill_data     (fill_data),
    .credit_return (credit_return)
  );

  mem_request_ctrl #(.MSHR_DEPTH(MSHR_DEPTH)) i_mem_ctrl (
    .clock        (clock),
    .reset        (reset),
    .head_entry   (head_entry),
    .mem_response (mem_response),
    .mem_cmd      (mem_cmd),
    .mem_addr     (mem_addr),
    .mem_data     (mem_data),
    .accept       (accept),
    .accept_tag   (accept_tag)
  );

endmodule

`default_nettype wire

//--- tb/tb_mshr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mshr import mshr_pkg::*; ();

  localparam int MSHR_DEPTH    = 8;
  localparam int RUN_CYCLES    = 4000;
  localparam int DRAIN_TIMEOUT = 3000;
  localparam line_data_t FILL_PATTERN = 64'h5a5a_0f0f_c3c3_9696;

  logic        clock;
  logic        reset;
  logic        reset_d = 1'b0;
  logic        stim_on;
  miss_req_t   load_req;
  miss_req_t   wb_req;
  logic        fwd_valid;
  line_data_t  fwd_data;
  logic        fill_valid;
  line_addr_t  fill_addr;
  line_data_t  fill_data;
  credit_cnt_t credit_return;
  bus_cmd_e    mem_cmd;
  line_addr_t  mem_addr;
  line_data_t  mem_data;
  mem_tag_t    mem_response;
  mem_tag_t    mem_tag;
  line_data_t  mem_resp_data;

  integer     seed = 32'ha1e2;
  int         credits;
  int         accept_delay;
  int         resp_delay;
  mem_tag_t   next_tag;
  mem_tag_t   resp_tag_q[$];
  line_addr_t resp_addr_q[$];

  // loads waiting for a fill, accepted loads, waiting wb and newest wb data per pool line
  int         load_wait[4];
  int         loads_open[4];
  logic       store_waiting[4];
  line_data_t wb_latest[4];
  line_data_t fwd_expect;
  line_data_t store_expect;

  function automatic line_addr_t pool_addr(input int idx);
    return 32'h0000_4000 | line_addr_t'((idx & 3) << 6);
  endfunction

  function automatic logic [1:0] pool_index(input line_addr_t addr);
    return addr[7:6];
  endfunction

  assign fwd_expect   = wb_latest[pool_index(load_req.addr)];
  assign store_expect = wb_latest[pool_index(mem_addr)];

  mshr_top #(.MSHR_DEPTH(MSHR_DEPTH)) i_dut (
    .clock         (clock),
    .reset         (reset),
    .load_req      (load_req),
    .wb_req        (wb_req),
    .fwd_valid     (fwd_valid),
    .fwd_data      (fwd_data),
    .fill_valid    (fill_valid),
    .fill_addr     (fill_addr),
    .fill_data     (fill_data),
    .credit_return (credit_return),
    .mem_cmd       (mem_cmd),
    .mem_addr      (mem_addr),
    .mem_data      (mem_data),
    .mem_response  (mem_response),
    .mem_tag       (mem_tag),
    .mem_resp_data (mem_resp_data)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    report_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  // bookkeeping from the values seen just before the edge
  task automatic update_scoreboard();
    if (load_req.valid && !fwd_valid) begin
      load_wait[pool_index(load_req.addr)]++;
    end
    if (mem_response != '0 && mem_cmd == BUS_LOAD) begin
      loads_open[pool_index(mem_addr)]++;
    end
    if (mem_response != '0 && mem_cmd == BUS_STORE) begin
      store_waiting[pool_index(mem_addr)] = 1'b0;
    end
    if (wb_req.valid) begin
      store_waiting[pool_index(wb_req.addr)] = 1'b1;
      wb_latest[pool_index(wb_req.addr)]     = wb_req.data;
    end
    // a fill also serves every load merged into it
    if (fill_valid) begin
      load_wait[pool_index(fill_addr)] = 0;
      loads_open[pool_index(fill_addr)]--;
    end
  endtask

  task automatic drive_memory();
    mem_tag <= '0;
    if (mem_response != '0) begin
      if (mem_cmd == BUS_LOAD) begin
        resp_tag_q.push_back(mem_response);
        resp_addr_q.push_back(mem_addr);
      end
      mem_response <= '0;
      accept_delay = $random(seed) & 7;
      // occasional long stall so the queue fills up
      if (($random(seed) & 31) == 0) begin
        accept_delay = 40;
      end
    end else if (mem_cmd != BUS_NONE) begin
      if (accept_delay == 0) begin
        mem_response <= next_tag;
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end else begin
        accept_delay--;
      end
    end
    if (resp_tag_q.size() > 0) begin
      if (resp_delay == 0) begin
        mem_tag       <= resp_tag_q.pop_front();
        mem_resp_data <= {32'h0, resp_addr_q.pop_front()} ^ FILL_PATTERN;
        resp_delay = $random(seed) & 7;
      end else begin
        resp_delay--;
      end
    end
  endtask

  task automatic drive_cache();
    int        avail;
    int        n_new;
    miss_req_t next_load;
    miss_req_t next_wb;
    avail     = credits + int'(credit_return);
    n_new     = 0;
    next_load = '0;
    next_wb   = '0;
    if (stim_on && avail > 0 && ($random(seed) & 1) == 1) begin
      next_load.valid = 1'b1;
      next_load.addr  = pool_addr($random(seed) & 3);
      n_new++;
    end
    if (stim_on && avail > n_new && ($random(seed) & 3) == 0) begin
      next_wb.valid = 1'b1;
      next_wb.addr  = pool_addr($random(seed) & 3);
      next_wb.data  = {$random(seed), $random(seed)};
      n_new++;
    end
    load_req <= next_load;
    wb_req   <= next_wb;
    credits  <= avail - n_new;
  endtask

  always @(posedge clock) begin
    reset_d <= reset;
    if (reset) begin
      load_req      <= '0;
      wb_req        <= '0;
      mem_response  <= '0;
      mem_tag       <= '0;
      mem_resp_data <= '0;
      credits       <= MSHR_DEPTH;
      accept_delay = 0;
      resp_delay   = 0;
      next_tag     = 4'd1;
      resp_tag_q.delete();
      resp_addr_q.delete();
      for (int i = 0; i < 4; i++) begin
        load_wait[i]     = 0;
        loads_open[i]    = 0;
        store_waiting[i] = 1'b0;
        wb_latest[i]     = '0;
      end
    end else begin
      update_scoreboard();
      drive_memory();
      drive_cache();
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    fill_valid |-> fill_data == ({32'h0, fill_addr} ^ FILL_PATTERN))
    else report_mismatch("fill_data", $sampled(fill_data),
                         {32'h0, $sampled(fill_addr)} ^ FILL_PATTERN);

  assert property (@(posedge clock) disable iff (reset)
    fill_valid |-> loads_open[pool_index(fill_addr)] == 1 &&
                   load_wait[pool_index(fill_addr)] > 0)
    else report_error("fill for a line with no outstanding load");

  assert property (@(posedge clock) disable iff (reset)
    load_req.valid && store_waiting[pool_index(load_req.addr)] |-> fwd_valid)
    else report_mismatch("fwd_valid", 64'($sampled(fwd_valid)), 64'h1);

  assert property (@(posedge clock) disable iff (reset)
    fwd_valid |-> fwd_data == fwd_expect)
    else report_mismatch("fwd_data", $sampled(fwd_data), $sampled(fwd_expect));

  // one BUS_LOAD per line at a time, and only for a load that needs it
  assert property (@(posedge clock) disable iff (reset)
    mem_cmd == BUS_LOAD && mem_response != '0 |->
      loads_open[pool_index(mem_addr)] == 0 && load_wait[pool_index(mem_addr)] > 0)
    else report_error("BUS_LOAD accepted for a line that is already loading or not requested");

  assert property (@(posedge clock) disable iff (reset)
    mem_cmd == BUS_STORE && mem_response != '0 |-> store_waiting[pool_index(mem_addr)])
    else report_error("BUS_STORE accepted for a line with no waiting writeback");

  assert property (@(posedge clock) disable iff (reset)
    mem_cmd == BUS_STORE && mem_response != '0 |-> mem_data == store_expect)
    else report_mismatch("mem_data", $sampled(mem_data), $sampled(store_expect));

  assert property (@(posedge clock) disable iff (reset)
    credits >= 0 && credits <= MSHR_DEPTH)
    else report_error("credit counter left the range 0 to MSHR_DEPTH");

  assert property (@(posedge clock) reset_d |-> mem_cmd == BUS_NONE)
    else report_mismatch("mem_cmd", 64'($sampled(mem_cmd)), 64'(BUS_NONE));

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    int wait_cycles;
    int leftover;
    reset         = 1'b1;
    stim_on       = 1'b0;
    load_req      = '0;
    wb_req        = '0;
    mem_response  = '0;
    mem_tag       = '0;
    mem_resp_data = '0;
    repeat (10) @(posedge clock);
    reset   <= 1'b0;
    stim_on <= 1'b1;
    repeat (RUN_CYCLES) @(posedge clock);
    stim_on <= 1'b0;
    repeat (2) @(posedge clock);
    wait_cycles = 0;
    while (credits != MSHR_DEPTH && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge clock);
      wait_cycles++;
    end
    if (credits != MSHR_DEPTH) begin
      report_error("timeout waiting for all credits to return");
    end else begin
      @(negedge clock);
      leftover = 0;
      for (int i = 0; i < 4; i++) begin
        leftover += load_wait[i] + loads_open[i] + int'(store_waiting[i]);
      end
      if (leftover == 0) begin
        $display("RESULT: PASS");
        $finish;
      end else begin
        report_error("requests left without a fill or a bus command after drain");
      end
    end
  end

endmodule

`default_nettype wire

//--- src.f
src/mshr_pkg.sv
src/load_miss_filter.sv
src/writeback_filter.sv
src/mshr_entry_table.sv
src/mem_request_ctrl.sv
src/mshr_top.sv
tb/tb_mshr.sv

//--- Bender.yml
package:
  name: mshr

sources:
  - src/mshr_pkg.sv
  - src/load_miss_filter.sv
  - src/writeback_filter.sv
  - src/mshr_entry_table.sv
  - src/mem_request_ctrl.sv
  - src/mshr_top.sv
  - target: simulation
    files:
      - tb/tb_mshr.sv
